/* include/cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath and register file sizes
`define XLEN        32
`define NUM_REGS    32
`define REG_ADDR_W  5

// accepted major opcodes
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111

// funct3 codes, shared by OP and OP-IMM
`define F3_ADD      3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SR       3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// funct7 that selects SUB / SRA / SRAI
`define F7_ALT      7'b0100000

`endif

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f src.f --top-module tb_cpu -o sim_tb_cpu

# status of the pipeline is the status of grep
./obj_dir/sim_tb_cpu | tee /dev/stderr | grep "SIMULATION PASSED" > /dev/null

/* src.f */
+incdir+include
verilog/cpu_pkg.sv
verilog/regfile.sv
verilog/forwarding_unit.sv
verilog/alu.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/cpu.sv
tb/cpu_properties.sv
tb/tb_cpu.sv

/* tb/cpu_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_properties (
    input logic               clk_i,
    input logic               rst_n_i,
    input logic               instr_valid_i,
    input cpu_pkg::word_t     instr_i,
    input logic               wb_valid_o,
    input cpu_pkg::reg_addr_t wb_rd_o
);

    // ID/EX, EX/MEM, MEM/WB between strobe and writeback
    a_strobe_retires: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
            instr_valid_i |-> ##3 wb_valid_o
    ) else $error("no writeback three cycles after an instruction strobe");

    // every writeback traces back to a strobe
    a_no_extra_wb: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
            wb_valid_o |-> $past(instr_valid_i, 3)
    ) else $error("writeback strobe without an instruction three cycles earlier");

    // rd field rides along with its instruction
    a_rd_tracks_instr: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
            wb_valid_o |-> (wb_rd_o == $past(instr_i[11:7], 3))
    ) else $error("writeback rd differs from the rd field three cycles earlier");

endmodule

bind cpu cpu_properties u_cpu_props (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .wb_valid_o    (wb_valid_o),
    .wb_rd_o       (wb_rd_o)
);

`default_nettype wire

/* tb/tb_cpu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defines.svh"

module tb_cpu;
    import cpu_pkg::*;

    localparam int RAND_COUNT  = 4000;
    localparam int DRAIN_LIMIT = 100;
    // ID/EX, EX/MEM, MEM/WB
    localparam int LATENCY     = 3;

    logic      clk;
    logic      rst_n;
    logic      instr_valid;
    word_t     instr;
    logic      wb_valid;
    reg_addr_t wb_rd;
    word_t     wb_data;

    integer    seed;
    int        rd_errs;
    int        data_errs;
    int        strobe_errs;
    int        lat_errs;
    // rising edges seen so far
    int        cyc;
    // reference register file, x0 never written
    word_t     model_regs [0:`NUM_REGS-1];
    reg_addr_t exp_rd_q [$];
    word_t     exp_data_q [$];
    int        exp_cyc_q [$];
    // last three destinations, reused as sources
    reg_addr_t recent [0:2];

    cpu dut_i (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .wb_valid_o    (wb_valid),
        .wb_rd_o       (wb_rd),
        .wb_data_o     (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk)
        cyc <= cyc + 1;

    task automatic check_rd(input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            rd_errs++;
            $display("ERR %0t wb_rd_o got %0d exp %0d", $time, got, exp);
        end
    endtask

    task automatic check_data(input word_t got, input word_t exp);
        if (got !== exp) begin
            data_errs++;
            $display("ERR %0t wb_data_o got %08h exp %08h", $time, got, exp);
        end
    endtask

    // writeback must land exactly on its cycle
    task automatic check_latency(input reg_addr_t rd, input int exp_cyc);
        if (cyc != exp_cyc) begin
            lat_errs++;
            $display("instruction writing x%0d retired at cycle %0d instead of cycle %0d",
                     rd, cyc, exp_cyc);
        end
    endtask

    // RV32I semantics for OP, OP-IMM and LUI
    function automatic word_t model_exec(input word_t ins);
        logic [6:0] opc;
        logic [2:0] f3;
        logic       alt;
        word_t      a;
        word_t      b;
        opc = ins[6:0];
        f3  = ins[14:12];
        alt = ins[30];
        a   = model_regs[ins[19:15]];
        if (opc == `OPC_LUI)
            return {ins[31:12], 12'b0};
        // R-type takes rs2, I-type the sign extended immediate
        if (opc == `OPC_OP)
            b = model_regs[ins[24:20]];
        else
            b = {{20{ins[31]}}, ins[31:20]};
        case (f3)
            `F3_ADD:  return (opc == `OPC_OP && alt) ? a - b : a + b;
            `F3_SLL:  return a << b[4:0];
            `F3_SLT:  return {31'b0, $signed(a) < $signed(b)};
            `F3_SLTU: return {31'b0, a < b};
            `F3_XOR:  return a ^ b;
            `F3_SR:   return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            `F3_OR:   return a | b;
            default:  return a & b;
        endcase
    endfunction

    // half the sources come from a recent destination
    function automatic reg_addr_t pick_reg();
        if (1'($random(seed)))
            return recent[2'($unsigned($random(seed)) % 3)];
        return reg_addr_t'($random(seed));
    endfunction

    // legal OP / OP-IMM / LUI word
    function automatic word_t rand_instr();
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic        is_r;
        int          kind;
        kind = $unsigned($random(seed)) % 10;
        f3   = 3'($random(seed));
        is_r = (kind < 5);
        // alternate encoding only for SUB, SRA and SRAI
        f7   = (1'($random(seed)) && (f3 == `F3_SR || (is_r && f3 == `F3_ADD))) ? `F7_ALT : 7'b0;
        imm  = 12'($random(seed));
        if (f3 == `F3_SLL || f3 == `F3_SR)
            imm = {f7, imm[4:0]};
        if (kind == 9)
            return {20'($random(seed)), reg_addr_t'($random(seed)), `OPC_LUI};
        if (is_r)
            return {f7, pick_reg(), pick_reg(), f3, reg_addr_t'($random(seed)), `OPC_OP};
        return {imm, pick_reg(), f3, reg_addr_t'($random(seed)), `OPC_OP_IMM};
    endfunction

    // run the model, strobe on the next edge, queue the result
    task automatic issue(input word_t ins);
        word_t     res;
        reg_addr_t rd;
        rd  = ins[11:7];
        res = model_exec(ins);
        if (rd != '0)
            model_regs[rd] = res;
        recent[2] = recent[1];
        recent[1] = recent[0];
        recent[0] = rd;
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= ins;
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(res);
        // sampled on the next edge, seen at the writeback LATENCY edges on
        exp_cyc_q.push_back(cyc + 1 + LATENCY);
    endtask

    // idle slots carry junk on instr
    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            instr_valid <= 1'b0;
            instr       <= 32'($random(seed));
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_rd_q.size() != 0 && n < DRAIN_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (exp_rd_q.size() != 0) begin
            strobe_errs++;
            $display("timeout, %0d instructions never retired", exp_rd_q.size());
        end
    endtask

    // writeback monitor, outputs settled by the falling edge
    always @(negedge clk) begin
        if (rst_n && wb_valid) begin
            if (exp_rd_q.size() == 0) begin
                strobe_errs++;
                $display("writeback strobe at %0t with nothing in flight", $time);
            end else begin
                check_latency(wb_rd, exp_cyc_q.pop_front());
                check_rd(wb_rd, exp_rd_q.pop_front());
                check_data(wb_data, exp_data_q.pop_front());
            end
        end
    end

    initial begin
        reg_addr_t r;
        seed        = 32'h5c30;
        cyc         = 0;
        rd_errs     = 0;
        data_errs   = 0;
        strobe_errs = 0;
        lat_errs    = 0;
        rst_n       <= 1'b0;
        instr_valid <= 1'b0;
        instr       <= '0;
        for (int i = 0; i < `NUM_REGS; i++)
            model_regs[i] = '0;
        for (int i = 0; i < 3; i++)
            recent[i] = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        // quiet pipe after reset, monitor flags any strobe
        idle(8);
        // preload, LUI then ADDI on the same rd at distance 1
        for (int i = 1; i < `NUM_REGS; i++) begin
            r = reg_addr_t'(i);
            issue({20'($random(seed)), r, `OPC_LUI});
            issue({12'($random(seed)), r, `F3_ADD, r, `OPC_OP_IMM});
        end
        // every R and I op, SUB / SRA / SRAI included
        for (int k = 0; k < 8; k++) begin
            for (int f = 0; f < 8; f++) begin
                issue({7'b0, pick_reg(), pick_reg(), 3'(f), pick_reg(), `OPC_OP});
                issue({12'($random(seed)) & 12'h01f, pick_reg(), 3'(f), pick_reg(), `OPC_OP_IMM});
                if (f == 0 || f == 5)
                    issue({`F7_ALT, pick_reg(), pick_reg(), 3'(f), pick_reg(), `OPC_OP});
                if (f == 5)
                    issue({`F7_ALT, 5'($random(seed)), pick_reg(), 3'(f), pick_reg(), `OPC_OP_IMM});
                if (f != 1 && f != 5)
                    issue({12'($random(seed)), pick_reg(), 3'(f), pick_reg(), `OPC_OP_IMM});
            end
        end
        idle(2);
        // chains at distance 1, 2, 3 back to back
        for (int d = 1; d <= 3; d++) begin
            for (int k = 0; k < 12; k++) begin
                r = reg_addr_t'(1 + k % d);
                if (k % 2 == 1)
                    issue({7'b0, r, r, `F3_ADD, r, `OPC_OP});
                else
                    issue({12'($random(seed)), r, `F3_ADD, r, `OPC_OP_IMM});
            end
            idle(1);
        end
        // x0 as destination, then as source
        issue({12'($random(seed)), 5'd3, `F3_ADD, 5'd0, `OPC_OP_IMM});
        issue({7'b0, 5'd4, 5'd5, `F3_XOR, 5'd0, `OPC_OP});
        issue({12'h123, 5'd0, `F3_ADD, 5'd7, `OPC_OP_IMM});
        issue({7'b0, 5'd0, 5'd0, `F3_OR, 5'd8, `OPC_OP});
        // long random mix at random density
        for (int k = 0; k < RAND_COUNT; k++) begin
            if ($unsigned($random(seed)) % 3 == 0)
                idle(1);
            issue(rand_instr());
        end
        idle(1);
        drain();
        // window for late extra strobes
        idle(6);
        $display("errors: rd %0d, data %0d, strobe %0d, latency %0d",
                 rd_errs, data_errs, strobe_errs, lat_errs);
        if (rd_errs + data_errs + strobe_errs + lat_errs == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  cpu_pkg::word_t  op_a_i,
    input  cpu_pkg::word_t  op_b_i,
    input  cpu_pkg::alu_op_e op_i,
    output cpu_pkg::word_t  result_o
);
    import cpu_pkg::*;

    // shift amount, low 5 bits of operand 2
    logic [4:0] shamt;

    assign shamt = op_b_i[4:0];

    always_comb begin
        case (op_i)
            ALU_ADD:    result_o = op_a_i + op_b_i;
            ALU_SUB:    result_o = op_a_i - op_b_i;
            ALU_SLL:    result_o = op_a_i << shamt;
            // signed compare
            ALU_SLT:    result_o = word_t'($signed(op_a_i) < $signed(op_b_i));
            // unsigned compare
            ALU_SLTU:   result_o = word_t'(op_a_i < op_b_i);
            ALU_XOR:    result_o = op_a_i ^ op_b_i;
            ALU_SRL:    result_o = op_a_i >> shamt;
            // arithmetic, sign bit fills from the left
            ALU_SRA:    result_o = word_t'($signed(op_a_i) >>> shamt);
            ALU_OR:     result_o = op_a_i | op_b_i;
            ALU_AND:    result_o = op_a_i & op_b_i;
            // LUI path
            ALU_PASS_B: result_o = op_b_i;
            default:    result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/cpu.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               instr_valid_i,
    input  cpu_pkg::word_t     instr_i,
    output logic               wb_valid_o,
    output cpu_pkg::reg_addr_t wb_rd_o,
    output cpu_pkg::word_t     wb_data_o
);
    import cpu_pkg::*;

    // ID/EX
    logic    id_ex_valid;
    id_ex_t  id_ex;

    // MEM/WB, also the regfile write port
    logic    mem_wb_valid;
    ex_mem_t mem_wb;
    logic    rf_we;

    // only a live slot with write enable touches the regfile
    assign rf_we = mem_wb_valid & mem_wb.we;

    decode_stage u_id (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .wb_we_i       (rf_we),
        .wb_rd_i       (mem_wb.rd),
        .wb_data_i     (mem_wb.result),
        .id_ex_valid_o (id_ex_valid),
        .id_ex_o       (id_ex)
    );

    execute_stage u_ex (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .id_ex_valid_i (id_ex_valid),
        .id_ex_i       (id_ex),
        .wb_valid_o    (mem_wb_valid),
        .wb_o          (mem_wb)
    );

    // writeback port, every slot retires even with we low
    assign wb_valid_o = mem_wb_valid;
    assign wb_rd_o    = mem_wb.rd;
    assign wb_data_o  = mem_wb.result;

endmodule

`default_nettype wire

/* verilog/cpu_pkg.sv */
`default_nettype none

`include "cpu_defines.svh"

package cpu_pkg;

    // one data word
    typedef logic [`XLEN-1:0] word_t;

    // architectural register index
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // alu operations
    // PASS_B copies operand 2, used by LUI
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

    // operand source select for EX
    // code 3 is spare and falls back to the regfile value
    typedef enum logic [1:0] {
        FWD_REGFILE = 2'd0,
        FWD_MEM_WB  = 2'd1,
        FWD_EX_MEM  = 2'd2
    } fwd_sel_e;

    // ID/EX payload
    typedef struct packed {
        word_t     rs1_val;
        word_t     rs2_val;
        word_t     imm;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        alu_op_e   alu_op;
        // operand 2 comes from imm
        logic      op2_imm;
        logic      we;
    } id_ex_t;

    // EX/MEM and MEM/WB payload
    typedef struct packed {
        word_t     result;
        reg_addr_t rd;
        logic      we;
    } ex_mem_t;

endpackage

`default_nettype wire

/* verilog/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defines.svh"

module decode_stage (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               instr_valid_i,
    input  cpu_pkg::word_t     instr_i,
    input  logic               wb_we_i,
    input  cpu_pkg::reg_addr_t wb_rd_i,
    input  cpu_pkg::word_t     wb_data_i,
    output logic               id_ex_valid_o,
    output cpu_pkg::id_ex_t    id_ex_o
);
    import cpu_pkg::*;

    // instruction fields
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;

    word_t      rs1_data;
    word_t      rs2_data;
    alu_op_e    base_op;
    id_ex_t     id_ex_d;

    assign opcode = instr_i[6:0];
    assign rd     = instr_i[11:7];
    assign funct3 = instr_i[14:12];
    assign rs1    = instr_i[19:15];
    assign rs2    = instr_i[24:20];
    assign funct7 = instr_i[31:25];

    // register read, written back from MEM/WB
    regfile u_regfile (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rs1),
        .rs2_addr_i (rs2),
        .we_i       (wb_we_i),
        .wr_addr_i  (wb_rd_i),
        .wr_data_i  (wb_data_i),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    // funct3 -> alu op, funct7 picks SUB / SRA
    always_comb begin
        case (funct3)
            // SUB only exists in R-type, ADDI ignores funct7
            `F3_ADD:  base_op = (opcode == `OPC_OP && funct7 == `F7_ALT) ? ALU_SUB : ALU_ADD;
            `F3_SLL:  base_op = ALU_SLL;
            `F3_SLT:  base_op = ALU_SLT;
            `F3_SLTU: base_op = ALU_SLTU;
            `F3_XOR:  base_op = ALU_XOR;
            `F3_SR:   base_op = (funct7 == `F7_ALT) ? ALU_SRA : ALU_SRL;
            `F3_OR:   base_op = ALU_OR;
            `F3_AND:  base_op = ALU_AND;
        endcase
    end

    // control decode and immediate generation
    always_comb begin
        id_ex_d.rs1_val = rs1_data;
        id_ex_d.rs2_val = rs2_data;
        id_ex_d.imm     = '0;
        id_ex_d.rs1     = rs1;
        id_ex_d.rs2     = '0;
        id_ex_d.rd      = rd;
        id_ex_d.alu_op  = base_op;
        id_ex_d.op2_imm = 1'b0;
        id_ex_d.we      = 1'b1;
        case (opcode)
            `OPC_OP: begin
                // both sources live
                id_ex_d.rs2 = rs2;
            end
            `OPC_OP_IMM: begin
                // I immediate, sign extended
                id_ex_d.imm     = {{(`XLEN-12){instr_i[31]}}, instr_i[31:20]};
                id_ex_d.op2_imm = 1'b1;
            end
            `OPC_LUI: begin
                // U immediate, rs1 field is immediate bits here
                id_ex_d.imm     = {instr_i[31:12], 12'b0};
                id_ex_d.op2_imm = 1'b1;
                id_ex_d.alu_op  = ALU_PASS_B;
                id_ex_d.rs1     = '0;
            end
            default: begin
                // unknown opcode still retires, writes nothing
                id_ex_d.we  = 1'b0;
                id_ex_d.rs1 = '0;
            end
        endcase
    end

    // ID/EX valid
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i)
            id_ex_valid_o <= 1'b0;
        else
            id_ex_valid_o <= instr_valid_i;
    end

    // ID/EX payload, loaded only with a new instruction
    always_ff @(posedge clk_i) begin
        if (instr_valid_i)
            id_ex_o <= id_ex_d;
    end

endmodule

`default_nettype wire

/* verilog/execute_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             id_ex_valid_i,
    input  cpu_pkg::id_ex_t  id_ex_i,
    output logic             wb_valid_o,
    output cpu_pkg::ex_mem_t wb_o
);
    import cpu_pkg::*;

    logic     ex_mem_valid;
    ex_mem_t  ex_mem;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;
    word_t    rs1_fwd;
    word_t    rs2_fwd;
    word_t    op_b;
    word_t    alu_result;

    // 4-way operand select, spare code falls back to the ID/EX value
    function automatic word_t pick_operand(input fwd_sel_e sel, input word_t reg_val,
                                           input word_t ex_mem_val, input word_t mem_wb_val);
        case (sel)
            FWD_EX_MEM: return ex_mem_val;
            FWD_MEM_WB: return mem_wb_val;
            default:    return reg_val;
        endcase
    endfunction

    forwarding_unit u_forwarding_unit (
        .rs1_i          (id_ex_i.rs1),
        .rs2_i          (id_ex_i.rs2),
        .ex_mem_valid_i (ex_mem_valid),
        .ex_mem_rd_i    (ex_mem.rd),
        .mem_wb_valid_i (wb_valid_o),
        .mem_wb_rd_i    (wb_o.rd),
        .ex_mem_we_i    (ex_mem.we),
        .mem_wb_we_i    (wb_o.we),
        .fwd_a_o        (fwd_a),
        .fwd_b_o        (fwd_b)
    );

    assign rs1_fwd = pick_operand(fwd_a, id_ex_i.rs1_val, ex_mem.result, wb_o.result);
    assign rs2_fwd = pick_operand(fwd_b, id_ex_i.rs2_val, ex_mem.result, wb_o.result);

    // immediate replaces rs2 for OP-IMM and LUI
    assign op_b = id_ex_i.op2_imm ? id_ex_i.imm : rs2_fwd;

    alu u_alu (
        .op_a_i   (rs1_fwd),
        .op_b_i   (op_b),
        .op_i     (id_ex_i.alu_op),
        .result_o (alu_result)
    );

    // valid bits for EX/MEM and MEM/WB
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_mem_valid <= 1'b0;
            wb_valid_o   <= 1'b0;
        end else begin
            ex_mem_valid <= id_ex_valid_i;
            wb_valid_o   <= ex_mem_valid;
        end
    end

    // payloads move only behind a valid slot
    always_ff @(posedge clk_i) begin
        if (id_ex_valid_i) begin
            ex_mem.result <= alu_result;
            ex_mem.rd     <= id_ex_i.rd;
            ex_mem.we     <= id_ex_i.we;
        end
        // no data memory, MEM/WB is a plain copy
        if (ex_mem_valid)
            wb_o <= ex_mem;
    end

endmodule

`default_nettype wire

/* verilog/forwarding_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module forwarding_unit (
    input  cpu_pkg::reg_addr_t rs1_i,
    input  cpu_pkg::reg_addr_t rs2_i,
    input  logic               ex_mem_valid_i,
    input  cpu_pkg::reg_addr_t ex_mem_rd_i,
    input  logic               mem_wb_valid_i,
    input  cpu_pkg::reg_addr_t mem_wb_rd_i,
    input  logic               ex_mem_we_i,
    input  logic               mem_wb_we_i,
    output cpu_pkg::fwd_sel_e  fwd_a_o,
    output cpu_pkg::fwd_sel_e  fwd_b_o
);
    import cpu_pkg::*;

    // newest producer wins
    // x0 is never forwarded
    function automatic fwd_sel_e pick_source(input reg_addr_t src);
        if (src == '0)
            return FWD_REGFILE;
        if (ex_mem_valid_i && ex_mem_we_i && (ex_mem_rd_i == src))
            return FWD_EX_MEM;
        if (mem_wb_valid_i && mem_wb_we_i && (mem_wb_rd_i == src))
            return FWD_MEM_WB;
        // distance 3 and more is covered by the regfile bypass
        return FWD_REGFILE;
    endfunction

    assign fwd_a_o = pick_source(rs1_i);
    assign fwd_b_o = pick_source(rs2_i);

endmodule

`default_nettype wire

/* verilog/regfile.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defines.svh"

module regfile (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  cpu_pkg::reg_addr_t rs1_addr_i,
    input  cpu_pkg::reg_addr_t rs2_addr_i,
    input  logic               we_i,
    input  cpu_pkg::reg_addr_t wr_addr_i,
    input  cpu_pkg::word_t     wr_data_i,
    output cpu_pkg::word_t     rs1_data_o,
    output cpu_pkg::word_t     rs2_data_o
);
    import cpu_pkg::*;

    // x1..x31 only, x0 has no storage
    word_t regs [1:`NUM_REGS-1];

    // read port with write-through bypass
    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0)
            return '0;
        // same-cycle write wins over the stored value
        if (we_i && (wr_addr_i == addr))
            return wr_data_i;
        return regs[addr];
    endfunction

    assign rs1_data_o = read_port(rs1_addr_i);
    assign rs2_data_o = read_port(rs2_addr_i);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < `NUM_REGS; i++)
                regs[i] <= '0;
        end else if (we_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

endmodule

`default_nettype wire
